// File: sim.f
source/mci_pkg.sv
source/mci_boot_if.sv
source/mci_wdt_if.sv
source/mci_boot_seqr.sv
source/mci_wdt.sv
source/mci_csr_bank.sv
source/mci_top.sv
testbench/mci_top_asserts.sv
testbench/tb_mci_top.sv

// File: run_sim.sh
#!/bin/sh
# Compile the testbench with Verilator, run it and look for the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mci_top -f sim.f -o sim_mci

out=$(./obj_dir/sim_mci 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

// File: testbench/tb_mci_top.sv
// Module tb_mci_top, clock, reset, bus tasks, compare tasks and directed tests for mci_top
`timescale 1ns/1ps

module tb_mci_top;

    localparam int CLK_PERIOD     = 8;
    localparam int RESET_CYCLES   = 16;
    localparam int BUS_WAIT       = 8;
    // Longest t1 plus t2 draw with settling
    localparam int WDT_MAX_CYCLES = 120;
    localparam int TEST_CYCLES    = 6 * RESET_CYCLES + 3 * WDT_MAX_CYCLES + 400;
    localparam int TIMEOUT_NS     = 2 * TEST_CYCLES * CLK_PERIOD;

    logic               clk;
    logic               rst_n_i;
    logic               req_valid_i;
    logic               req_ready_o;
    logic               req_write_i;
    mci_pkg::csr_addr_t req_addr_i;
    mci_pkg::csr_data_t req_wdata_i;
    mci_pkg::axi_user_t req_user_i;
    logic               rsp_valid_o;
    logic               rsp_ready_i;
    mci_pkg::csr_data_t rsp_rdata_o;
    logic               rsp_error_o;
    mci_pkg::axi_user_t strap_soc_config_user_i;
    logic               boot_seq_brkpoint_i;
    logic               fc_opt_done_i;
    logic               fc_opt_init_o;
    logic               lc_done_i;
    logic               lc_init_o;
    logic               mcu_rst_b_o;
    logic               cptra_rst_b_o;
    mci_pkg::csr_data_t generic_out_o;
    logic               wdt_intr_o;
    logic               nmi_intr_o;

    mci_pkg::axi_user_t priv_user;

    mci_top dut (.*);

    bind mci_top mci_top_asserts asserts_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish in %0d ns", TIMEOUT_NS);
        $display("sim failed");
        $fatal(1, "run stopped by the watchdog");
    end

    ////////////////////////////////////////
    // Failure reporting and compares
    ////////////////////////////////////////
    task automatic stop_run();
        $display("sim failed");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic report_problem(input string what);
        $display("Failure at %0t ns: %s", $time, what);
        stop_run();
    endtask

    task automatic compare_data(input string name, input mci_pkg::csr_data_t got,
                                input mci_pkg::csr_data_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic compare_state(input string name, input mci_pkg::boot_state_e got,
                                 input mci_pkg::boot_state_e exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %s (%0d), expected %s", $time, name,
                     got.name(), got, exp.name());
            stop_run();
        end
    endtask

    ////////////////////////////////////////
    // Reset, level waits and bus tasks
    ////////////////////////////////////////
    task automatic apply_reset(input logic brkpoint);
        @(negedge clk);
        rst_n_i             = 1'b0;
        req_valid_i         = 1'b0;
        req_write_i         = 1'b0;
        rsp_ready_i         = 1'b1;
        fc_opt_done_i       = 1'b0;
        lc_done_i           = 1'b0;
        boot_seq_brkpoint_i = brkpoint;
        repeat (RESET_CYCLES) @(negedge clk);
        compare_bit("req_ready_o", req_ready_o, 1'b1);
        compare_bit("rsp_valid_o", rsp_valid_o, 1'b0);
        compare_bit("mcu_rst_b_o", mcu_rst_b_o, 1'b0);
        compare_bit("cptra_rst_b_o", cptra_rst_b_o, 1'b0);
        compare_bit("fc_opt_init_o", fc_opt_init_o, 1'b0);
        compare_bit("lc_init_o", lc_init_o, 1'b0);
        compare_bit("wdt_intr_o", wdt_intr_o, 1'b0);
        compare_bit("nmi_intr_o", nmi_intr_o, 1'b0);
        rst_n_i = 1'b1;
    endtask

    function automatic logic sig_value(input string name);
        case (name)
            "fc_opt_init_o": return fc_opt_init_o;
            "lc_init_o":     return lc_init_o;
            "mcu_rst_b_o":   return mcu_rst_b_o;
            "cptra_rst_b_o": return cptra_rst_b_o;
            "wdt_intr_o":    return wdt_intr_o;
            "nmi_intr_o":    return nmi_intr_o;
            default:         return 1'bx;
        endcase
    endfunction

    // Counts falling edges until the level shows, bounded on both sides
    task automatic wait_level(input string name, input logic level,
                              input int min_cycles, input int max_cycles);
        int cnt;
        cnt = 0;
        while (sig_value(name) !== level) begin
            @(negedge clk);
            cnt++;
            if (cnt > max_cycles) begin
                report_problem($sformatf("%s did not reach %b within %0d cycles",
                                         name, level, max_cycles));
            end
        end
        if (cnt < min_cycles) begin
            report_problem($sformatf("%s reached %b after %0d cycles, not before %0d",
                                     name, level, cnt, min_cycles));
        end
    endtask

    task automatic bus_xfer(input logic write, input mci_pkg::csr_addr_t addr,
                            input mci_pkg::csr_data_t wdata, input mci_pkg::axi_user_t user,
                            output mci_pkg::csr_data_t rdata, output logic err);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (!req_ready_o) begin
            @(negedge clk);
            cnt++;
            if (cnt > BUS_WAIT) report_problem("bus request was never accepted");
        end
        req_valid_i = 1'b1;
        req_write_i = write;
        req_addr_i  = addr;
        req_wdata_i = wdata;
        req_user_i  = user;
        @(negedge clk);
        req_valid_i = 1'b0;
        req_write_i = 1'b0;
        cnt = 0;
        while (!rsp_valid_o) begin
            @(negedge clk);
            cnt++;
            if (cnt > BUS_WAIT) report_problem("no response arrived for the bus request");
        end
        rdata = rsp_rdata_o;
        err   = rsp_error_o;
    endtask

    task automatic csr_write(input mci_pkg::csr_addr_t addr, input mci_pkg::csr_data_t data,
                             input mci_pkg::axi_user_t user, output logic err);
        mci_pkg::csr_data_t unused;
        bus_xfer(1'b1, addr, data, user, unused, err);
    endtask

    task automatic csr_read(input mci_pkg::csr_addr_t addr, output mci_pkg::csr_data_t rdata,
                            output logic err);
        bus_xfer(1'b0, addr, '0, priv_user, rdata, err);
    endtask

    // Fuse then lifecycle init, both as level handshakes
    task automatic run_init_handshakes();
        wait_level("fc_opt_init_o", 1'b1, 0, 4);
        compare_bit("lc_init_o", lc_init_o, 1'b0);
        fc_opt_done_i = 1'b1;
        wait_level("fc_opt_init_o", 1'b0, 1, 4);
        fc_opt_done_i = 1'b0;
        wait_level("lc_init_o", 1'b1, 0, 4);
        lc_done_i = 1'b1;
        wait_level("lc_init_o", 1'b0, 1, 4);
        lc_done_i = 1'b0;
    endtask

    task automatic check_status(input mci_pkg::boot_state_e exp_state, input logic exp_once);
        mci_pkg::csr_data_t rdata;
        logic               err;
        csr_read(mci_pkg::CSR_BOOT_STATUS, rdata, err);
        compare_bit("rsp_error_o", err, 1'b0);
        compare_state("boot_state", mci_pkg::boot_state_e'(rdata[3:0]), exp_state);
        compare_bit("mcu_reset_once", rdata[4], exp_once);
    endtask

    ////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////
    task automatic test_normal_boot();
        logic err;
        apply_reset(1'b0);
        run_init_handshakes();
        wait_level("mcu_rst_b_o", 1'b1, 0, 2);
        compare_bit("cptra_rst_b_o", cptra_rst_b_o, 1'b0);
        check_status(mci_pkg::BOOT_MCU_RUN, 1'b0);
        csr_write(mci_pkg::CSR_CPTRA_GO, 32'h1, priv_user, err);
        compare_bit("rsp_error_o", err, 1'b0);
        wait_level("cptra_rst_b_o", 1'b1, 0, 4);
        check_status(mci_pkg::BOOT_DONE, 1'b0);
    endtask

    task automatic test_breakpoint();
        logic err;
        apply_reset(1'b1);
        run_init_handshakes();
        repeat (8) @(negedge clk);
        compare_bit("mcu_rst_b_o", mcu_rst_b_o, 1'b0);
        check_status(mci_pkg::BOOT_BRKPOINT, 1'b0);
        csr_write(mci_pkg::CSR_BOOT_GO, 32'h1, priv_user, err);
        compare_bit("rsp_error_o", err, 1'b0);
        wait_level("mcu_rst_b_o", 1'b1, 0, 4);
        check_status(mci_pkg::BOOT_MCU_RUN, 1'b0);
    endtask

    task automatic test_access_rules();
        mci_pkg::csr_data_t word;
        mci_pkg::csr_data_t rdata;
        mci_pkg::axi_user_t other_user;
        mci_pkg::csr_addr_t bad_addr;
        logic               err;
        apply_reset(1'b0);
        word       = $urandom;
        other_user = priv_user ^ ($urandom | 32'h1);
        bad_addr   = mci_pkg::csr_addr_t'(9 + ($urandom % 55));
        csr_write(mci_pkg::CSR_GENERIC_OUT, word, priv_user, err);
        compare_bit("rsp_error_o", err, 1'b0);
        compare_data("generic_out_o", generic_out_o, word);
        csr_read(mci_pkg::CSR_GENERIC_OUT, rdata, err);
        compare_data("rsp_rdata_o", rdata, word);
        // Unprivileged write is flagged and dropped
        csr_write(mci_pkg::CSR_GENERIC_OUT, ~word, other_user, err);
        compare_bit("rsp_error_o", err, 1'b1);
        compare_data("generic_out_o", generic_out_o, word);
        csr_read(bad_addr, rdata, err);
        compare_bit("rsp_error_o", err, 1'b1);
        compare_data("rsp_rdata_o", rdata, 32'h0);
        // Back-pressure on the response channel, once the last response is taken
        @(negedge clk);
        rsp_ready_i = 1'b0;
        csr_read(mci_pkg::CSR_GENERIC_OUT, rdata, err);
        repeat (5) begin
            @(negedge clk);
            compare_bit("rsp_valid_o", rsp_valid_o, 1'b1);
            compare_bit("req_ready_o", req_ready_o, 1'b0);
            compare_data("rsp_rdata_o", rsp_rdata_o, word);
        end
        rsp_ready_i = 1'b1;
        @(negedge clk);
        compare_bit("rsp_valid_o", rsp_valid_o, 1'b0);
    endtask

    task automatic start_watchdog(input int t1, input int t2);
        logic err;
        csr_write(mci_pkg::CSR_WDT_T1_PERIOD, t1, priv_user, err);
        csr_write(mci_pkg::CSR_WDT_T2_PERIOD, t2, priv_user, err);
        csr_write(mci_pkg::CSR_WDT_CTRL, 32'h1, priv_user, err);
        compare_bit("rsp_error_o", err, 1'b0);
    endtask

    task automatic test_wdt_serviced();
        mci_pkg::csr_data_t rdata;
        logic               err;
        int                 t1;
        int                 t2;
        apply_reset(1'b0);
        t1 = 20 + ($urandom % 20);
        t2 = 40 + ($urandom % 20);
        start_watchdog(t1, t2);
        wait_level("wdt_intr_o", 1'b1, t1 - 2, t1 + 4);
        csr_read(mci_pkg::CSR_WDT_STATUS, rdata, err);
        compare_data("wdt_status", rdata, 32'h1);
        csr_write(mci_pkg::CSR_WDT_STATUS, 32'h1, priv_user, err);
        wait_level("wdt_intr_o", 1'b0, 0, 3);
        repeat (t2 + 4) @(negedge clk);
        compare_bit("nmi_intr_o", nmi_intr_o, 1'b0);
    endtask

    task automatic test_wdt_cascade();
        mci_pkg::csr_data_t rdata;
        logic               err;
        int                 t1;
        int                 t2;
        apply_reset(1'b0);
        t1 = 10 + ($urandom % 10);
        t2 = 10 + ($urandom % 10);
        start_watchdog(t1, t2);
        wait_level("wdt_intr_o", 1'b1, t1 - 2, t1 + 4);
        wait_level("nmi_intr_o", 1'b1, t2 - 2, t2 + 4);
        repeat (10) @(negedge clk);
        compare_bit("nmi_intr_o", nmi_intr_o, 1'b1);
        csr_read(mci_pkg::CSR_WDT_STATUS, rdata, err);
        compare_data("wdt_status", rdata, 32'h3);
    endtask

    task automatic test_mcu_reset_request();
        logic err;
        apply_reset(1'b0);
        run_init_handshakes();
        csr_write(mci_pkg::CSR_CPTRA_GO, 32'h1, priv_user, err);
        wait_level("cptra_rst_b_o", 1'b1, 0, 4);
        csr_write(mci_pkg::CSR_RESET_REQUEST, 32'h1, priv_user, err);
        compare_bit("rsp_error_o", err, 1'b0);
        wait_level("mcu_rst_b_o", 1'b0, 0, 4);
        // Hold lasts exactly 16 cycles
        wait_level("mcu_rst_b_o", 1'b1, 16, 16);
        compare_bit("cptra_rst_b_o", cptra_rst_b_o, 1'b1);
        check_status(mci_pkg::BOOT_DONE, 1'b1);
    endtask

    initial begin
        void'($urandom(98));
        rst_n_i                 = 1'b0;
        req_valid_i             = 1'b0;
        req_write_i             = 1'b0;
        req_addr_i              = '0;
        req_wdata_i             = '0;
        req_user_i              = '0;
        rsp_ready_i             = 1'b1;
        boot_seq_brkpoint_i     = 1'b0;
        fc_opt_done_i           = 1'b0;
        lc_done_i               = 1'b0;
        priv_user               = $urandom;
        strap_soc_config_user_i = priv_user;

        test_normal_boot();
        test_breakpoint();
        test_access_rules();
        test_wdt_serviced();
        test_wdt_cascade();
        test_mcu_reset_request();

        $display("sim passed");
        $finish;
    end

endmodule

// File: testbench/mci_top_asserts.sv
// Module mci_top_asserts, concurrent checks on the bus and boot handshakes of mci_top
`timescale 1ns/1ps

module mci_top_asserts (
    input logic               clk,
    input logic               rst_n_i,
    input logic               req_ready_o,
    input logic               rsp_valid_o,
    input logic               rsp_ready_i,
    input mci_pkg::csr_data_t rsp_rdata_o,
    input logic               rsp_error_o,
    input logic               fc_opt_init_o,
    input logic               lc_init_o,
    input logic               nmi_intr_o
);

    ////////////////////////////////////////
    // Bus handshake
    ////////////////////////////////////////
    ready_while_pending: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(req_ready_o && rsp_valid_o))
        else $error("req_ready_o high while a response is pending");

    // Response held under back-pressure
    rsp_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        rsp_valid_o && !rsp_ready_i |=>
            rsp_valid_o && $stable(rsp_rdata_o) && $stable(rsp_error_o))
        else $error("response changed while stalled");

    ////////////////////////////////////////
    // Boot and watchdog
    ////////////////////////////////////////
    init_exclusive: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(fc_opt_init_o && lc_init_o))
        else $error("fuse and lifecycle init requested together");

    nmi_sticky: assert property (@(posedge clk) disable iff (!rst_n_i)
        !$fell(nmi_intr_o))
        else $error("nmi_intr_o dropped outside reset");

endmodule

// File: source/mci_top.sv
// Module mci_top, register bank, boot sequencer and watchdog behind plain ports
`timescale 1ns/1ps

module mci_top (
    input  logic               clk,
    input  logic               rst_n_i,

    // Register bus
    input  logic               req_valid_i,
    output logic               req_ready_o,
    input  logic               req_write_i,
    input  mci_pkg::csr_addr_t req_addr_i,
    input  mci_pkg::csr_data_t req_wdata_i,
    input  mci_pkg::axi_user_t req_user_i,
    output logic               rsp_valid_o,
    input  logic               rsp_ready_i,
    output mci_pkg::csr_data_t rsp_rdata_o,
    output logic               rsp_error_o,

    // Straps and SoC signals
    input  mci_pkg::axi_user_t strap_soc_config_user_i,
    input  logic               boot_seq_brkpoint_i,

    // Fuse and lifecycle handshakes
    input  logic               fc_opt_done_i,
    output logic               fc_opt_init_o,
    input  logic               lc_done_i,
    output logic               lc_init_o,

    // Reset controls
    output logic               mcu_rst_b_o,
    output logic               cptra_rst_b_o,

    // Misc outputs
    output mci_pkg::csr_data_t generic_out_o,
    output logic               wdt_intr_o,
    output logic               nmi_intr_o
);

    mci_boot_if boot_if ();
    mci_wdt_if  wdt_if ();

    mci_csr_bank i_mci_csr_bank (
        .clk,
        .rst_n_i,
        .req_valid_i,
        .req_ready_o,
        .req_write_i,
        .req_addr_i,
        .req_wdata_i,
        .req_user_i,
        .strap_soc_config_user_i,
        .rsp_valid_o,
        .rsp_ready_i,
        .rsp_rdata_o,
        .rsp_error_o,
        .generic_out_o,
        .boot_if (boot_if.csr),
        .wdt_if  (wdt_if.csr)
    );

    mci_boot_seqr i_mci_boot_seqr (
        .clk,
        .rst_n_i,
        .fc_opt_done_i,
        .lc_done_i,
        .boot_seq_brkpoint_i,
        .fc_opt_init_o,
        .lc_init_o,
        .mcu_rst_b_o,
        .cptra_rst_b_o,
        .boot_if (boot_if.seqr)
    );

    mci_wdt i_mci_wdt (
        .clk,
        .rst_n_i,
        .wdt_if (wdt_if.wdt)
    );

    // First stage is the maskable interrupt, second the NMI
    assign wdt_intr_o = wdt_if.t1_timeout;
    assign nmi_intr_o = wdt_if.t2_timeout;

endmodule

// File: source/mci_csr_bank.sv
// Module mci_csr_bank, valid/ready register slave with write privilege check
`timescale 1ns/1ps

module mci_csr_bank (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               req_valid_i,
    output logic               req_ready_o,
    input  logic               req_write_i,
    input  mci_pkg::csr_addr_t req_addr_i,
    input  mci_pkg::csr_data_t req_wdata_i,
    input  mci_pkg::axi_user_t req_user_i,
    input  mci_pkg::axi_user_t strap_soc_config_user_i,
    output logic               rsp_valid_o,
    input  logic               rsp_ready_i,
    output mci_pkg::csr_data_t rsp_rdata_o,
    output logic               rsp_error_o,
    output mci_pkg::csr_data_t generic_out_o,
    mci_boot_if.csr            boot_if,
    mci_wdt_if.csr             wdt_if
);

    logic                 req_fire;
    logic                 addr_hit;
    logic                 wr_priv;
    logic                 wr_en;
    mci_pkg::csr_data_t   rd_data;
    logic                 rsp_valid_q;
    mci_pkg::csr_data_t   rsp_rdata_q;
    logic                 rsp_error_q;
    logic                 boot_go_q;
    logic                 cptra_go_q;
    logic                 mcu_rst_req_q;
    logic                 timer_en_q;
    logic                 restart_q;
    logic                 t1_serviced_q;
    mci_pkg::wdt_period_t t1_period_q;
    mci_pkg::wdt_period_t t2_period_q;
    mci_pkg::csr_data_t   generic_out_q;

    // One transaction in flight at a time
    assign req_ready_o = !rsp_valid_q;
    assign req_fire    = req_valid_i && req_ready_o;
    assign wr_priv     = (req_user_i == strap_soc_config_user_i);
    assign wr_en       = req_fire && req_write_i && addr_hit && wr_priv;

    ////////////////////////////////////////
    // Address decode and read mux
    ////////////////////////////////////////
    always_comb begin
        rd_data  = '0;
        addr_hit = 1'b1;
        case (req_addr_i)
            mci_pkg::CSR_BOOT_GO:       rd_data[mci_pkg::GO_BIT] = boot_go_q;
            mci_pkg::CSR_CPTRA_GO:      rd_data[mci_pkg::GO_BIT] = cptra_go_q;
            mci_pkg::CSR_RESET_REQUEST: rd_data = '0;
            mci_pkg::CSR_BOOT_STATUS: begin
                rd_data[3:0]                   = boot_if.boot_state;
                rd_data[mci_pkg::RST_ONCE_BIT] = boot_if.mcu_reset_once;
            end
            mci_pkg::CSR_WDT_CTRL:      rd_data[mci_pkg::WDT_EN_BIT] = timer_en_q;
            mci_pkg::CSR_WDT_T1_PERIOD: rd_data = t1_period_q;
            mci_pkg::CSR_WDT_T2_PERIOD: rd_data = t2_period_q;
            mci_pkg::CSR_WDT_STATUS: begin
                rd_data[mci_pkg::WDT_T1_TO_BIT] = wdt_if.t1_timeout;
                rd_data[mci_pkg::WDT_T2_TO_BIT] = wdt_if.t2_timeout;
            end
            mci_pkg::CSR_GENERIC_OUT:   rd_data = generic_out_q;
            default:                    addr_hit = 1'b0;
        endcase
    end

    ////////////////////////////////////////
    // Response channel
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else if (req_fire) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    // Captured once per request, held under back-pressure
    always_ff @(posedge clk) begin
        if (req_fire) begin
            rsp_rdata_q <= req_write_i ? '0 : rd_data;
            rsp_error_q <= !addr_hit || (req_write_i && !wr_priv);
        end
    end

    // Control registers and self clearing pulses
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            boot_go_q     <= 1'b0;
            cptra_go_q    <= 1'b0;
            mcu_rst_req_q <= 1'b0;
            timer_en_q    <= 1'b0;
            restart_q     <= 1'b0;
            t1_serviced_q <= 1'b0;
            t1_period_q   <= '0;
            t2_period_q   <= '0;
            generic_out_q <= '0;
        end else begin
            mcu_rst_req_q <= 1'b0;
            restart_q     <= 1'b0;
            t1_serviced_q <= 1'b0;
            if (wr_en) begin
                case (req_addr_i)
                    mci_pkg::CSR_BOOT_GO:  boot_go_q  <= req_wdata_i[mci_pkg::GO_BIT];
                    mci_pkg::CSR_CPTRA_GO: cptra_go_q <= req_wdata_i[mci_pkg::GO_BIT];
                    mci_pkg::CSR_RESET_REQUEST: begin
                        mcu_rst_req_q <= req_wdata_i[mci_pkg::RST_REQ_BIT];
                    end
                    mci_pkg::CSR_WDT_CTRL: begin
                        timer_en_q <= req_wdata_i[mci_pkg::WDT_EN_BIT];
                        restart_q  <= req_wdata_i[mci_pkg::WDT_RESTART_BIT];
                    end
                    mci_pkg::CSR_WDT_T1_PERIOD: t1_period_q <= req_wdata_i;
                    mci_pkg::CSR_WDT_T2_PERIOD: t2_period_q <= req_wdata_i;
                    // W1C of the timer 1 timeout
                    mci_pkg::CSR_WDT_STATUS: t1_serviced_q <= req_wdata_i[mci_pkg::WDT_T1_TO_BIT];
                    mci_pkg::CSR_GENERIC_OUT: generic_out_q <= req_wdata_i;
                    default: ;
                endcase
            end
        end
    end

    assign rsp_valid_o   = rsp_valid_q;
    assign rsp_rdata_o   = rsp_rdata_q;
    assign rsp_error_o   = rsp_error_q;
    assign generic_out_o = generic_out_q;

    assign boot_if.boot_go     = boot_go_q;
    assign boot_if.cptra_go    = cptra_go_q;
    assign boot_if.mcu_rst_req = mcu_rst_req_q;
    assign wdt_if.timer_en     = timer_en_q;
    assign wdt_if.restart      = restart_q;
    assign wdt_if.t1_period    = t1_period_q;
    assign wdt_if.t2_period    = t2_period_q;
    assign wdt_if.t1_serviced  = t1_serviced_q;

endmodule

// File: source/mci_wdt.sv
// Module mci_wdt, cascaded two stage watchdog timer
`timescale 1ns/1ps

module mci_wdt (
    input  logic    clk,
    input  logic    rst_n_i,
    mci_wdt_if.wdt  wdt_if
);

    mci_pkg::wdt_period_t t1_cnt_q;
    mci_pkg::wdt_period_t t2_cnt_q;
    logic                 t1_to_q;
    logic                 t2_to_q;
    logic                 clear;

    // Any of these drops the first stage back to zero
    assign clear = !wdt_if.timer_en || wdt_if.restart || wdt_if.t1_serviced;

    ////////////////////////////////////////
    // Timer 1 then timer 2
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            t1_cnt_q <= '0;
            t2_cnt_q <= '0;
            t1_to_q  <= 1'b0;
            t2_to_q  <= 1'b0;
        end else if (clear) begin
            // t2_to_q is sticky and stays put
            t1_cnt_q <= '0;
            t2_cnt_q <= '0;
            t1_to_q  <= 1'b0;
        end else if (!t1_to_q) begin
            if (t1_cnt_q == wdt_if.t1_period) begin
                t1_to_q <= 1'b1;
            end else begin
                t1_cnt_q <= t1_cnt_q + 1'b1;
            end
        end else if (!t2_to_q) begin
            // Second stage runs only while the first timeout is pending
            if (t2_cnt_q == wdt_if.t2_period) begin
                t2_to_q <= 1'b1;
            end else begin
                t2_cnt_q <= t2_cnt_q + 1'b1;
            end
        end
    end

    // Interrupt levels
    assign wdt_if.t1_timeout = t1_to_q;
    assign wdt_if.t2_timeout = t2_to_q;

endmodule

// File: source/mci_boot_seqr.sv
// Module mci_boot_seqr, boot and reset sequencing FSM with MCU reset hold counter
`timescale 1ns/1ps

module mci_boot_seqr (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     fc_opt_done_i,
    input  logic     lc_done_i,
    input  logic     boot_seq_brkpoint_i,
    output logic     fc_opt_init_o,
    output logic     lc_init_o,
    output logic     mcu_rst_b_o,
    output logic     cptra_rst_b_o,
    mci_boot_if.seqr boot_if
);

    mci_pkg::boot_state_e              state_q;
    mci_pkg::boot_state_e              state_d;
    logic [mci_pkg::MCU_RST_CNT_W-1:0] rst_cnt_q;
    logic                              rst_cnt_done;
    logic                              cptra_rel_q;
    logic                              mcu_rst_b_q;
    logic                              mcu_reset_once_q;

    // Hold ends once the counter reaches all ones
    assign rst_cnt_done = &rst_cnt_q;

    ////////////////////////////////////////
    // Next state
    ////////////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            mci_pkg::BOOT_IDLE: begin
                state_d = mci_pkg::BOOT_FC_INIT;
            end
            mci_pkg::BOOT_FC_INIT: begin
                if (fc_opt_done_i) state_d = mci_pkg::BOOT_LC_INIT;
            end
            mci_pkg::BOOT_LC_INIT: begin
                if (lc_done_i) begin
                    if (boot_seq_brkpoint_i) state_d = mci_pkg::BOOT_BRKPOINT;
                    else                     state_d = mci_pkg::BOOT_MCU_RUN;
                end
            end
            mci_pkg::BOOT_BRKPOINT: begin
                if (boot_if.boot_go) state_d = mci_pkg::BOOT_MCU_RUN;
            end
            mci_pkg::BOOT_MCU_RUN: begin
                // reset request wins over a simultaneous Caliptra release
                if (boot_if.mcu_rst_req)   state_d = mci_pkg::BOOT_MCU_RST_REQ;
                else if (boot_if.cptra_go) state_d = mci_pkg::BOOT_DONE;
            end
            mci_pkg::BOOT_MCU_RST_REQ: begin
                if (rst_cnt_done) begin
                    if (cptra_rel_q) state_d = mci_pkg::BOOT_DONE;
                    else             state_d = mci_pkg::BOOT_MCU_RUN;
                end
            end
            mci_pkg::BOOT_DONE: begin
                if (boot_if.mcu_rst_req) state_d = mci_pkg::BOOT_MCU_RST_REQ;
            end
            default: begin
                state_d = mci_pkg::BOOT_IDLE;
            end
        endcase
    end

    ////////////////////////////////////////
    // State and reset control flops
    ////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q          <= mci_pkg::BOOT_IDLE;
            rst_cnt_q        <= '0;
            cptra_rel_q      <= 1'b0;
            mcu_rst_b_q      <= 1'b0;
            mcu_reset_once_q <= 1'b0;
        end else begin
            state_q <= state_d;
            // Counts only while the MCU is held
            if (state_q == mci_pkg::BOOT_MCU_RST_REQ) rst_cnt_q <= rst_cnt_q + 1'b1;
            else                                      rst_cnt_q <= '0;
            if (state_q == mci_pkg::BOOT_MCU_RUN && state_d == mci_pkg::BOOT_DONE) begin
                cptra_rel_q <= 1'b1;
            end
            if (state_q == mci_pkg::BOOT_MCU_RST_REQ && rst_cnt_done) begin
                mcu_reset_once_q <= 1'b1;
            end
            // Glitch free MCU reset, follows the next state
            mcu_rst_b_q <= (state_d == mci_pkg::BOOT_MCU_RUN) ||
                           (state_d == mci_pkg::BOOT_DONE);
        end
    end

    // Init requests are level handshakes tied to the state
    assign fc_opt_init_o = (state_q == mci_pkg::BOOT_FC_INIT);
    assign lc_init_o     = (state_q == mci_pkg::BOOT_LC_INIT);
    assign mcu_rst_b_o   = mcu_rst_b_q;
    assign cptra_rst_b_o = cptra_rel_q;

    assign boot_if.boot_state     = state_q;
    assign boot_if.mcu_reset_once = mcu_reset_once_q;

endmodule

// File: source/mci_wdt_if.sv
// Interface mci_wdt_if between the register bank and the watchdog
`timescale 1ns/1ps

interface mci_wdt_if;

    // Controls from the register bank
    logic                 timer_en;
    logic                 restart;
    mci_pkg::wdt_period_t t1_period;
    mci_pkg::wdt_period_t t2_period;
    logic                 t1_serviced;

    // Timeout levels back from the timers
    logic                 t1_timeout;
    logic                 t2_timeout;

    modport csr (
        output timer_en,
        output restart,
        output t1_period,
        output t2_period,
        output t1_serviced,
        input  t1_timeout,
        input  t2_timeout
    );

    modport wdt (
        input  timer_en,
        input  restart,
        input  t1_period,
        input  t2_period,
        input  t1_serviced,
        output t1_timeout,
        output t2_timeout
    );

endinterface

// File: source/mci_boot_if.sv
// Interface mci_boot_if between the register bank and the boot sequencer
`timescale 1ns/1ps

interface mci_boot_if;

    // Firmware controls
    logic                 boot_go;
    logic                 cptra_go;
    logic                 mcu_rst_req;

    // Sequencer status
    mci_pkg::boot_state_e boot_state;
    logic                 mcu_reset_once;

    modport csr (
        output boot_go,
        output cptra_go,
        output mcu_rst_req,
        input  boot_state,
        input  mcu_reset_once
    );

    modport seqr (
        input  boot_go,
        input  cptra_go,
        input  mcu_rst_req,
        output boot_state,
        output mcu_reset_once
    );

endinterface

// File: source/mci_pkg.sv
// Package mci_pkg with bus widths, types, register map and field positions
package mci_pkg;

    ////////////////////////////////////////
    // Sizing
    ////////////////////////////////////////
    localparam int CSR_ADDR_W    = 6;
    localparam int CSR_DATA_W    = 32;
    localparam int AXI_USER_W    = 32;
    localparam int MCU_RST_CNT_W = 4;

    typedef logic [CSR_ADDR_W-1:0] csr_addr_t;
    typedef logic [CSR_DATA_W-1:0] csr_data_t;
    typedef logic [AXI_USER_W-1:0] axi_user_t;
    typedef logic [31:0]           wdt_period_t;

    // Boot sequencer states, BOOT_DONE has Caliptra out of reset
    typedef enum logic [3:0] {
        BOOT_IDLE        = 4'd0,
        BOOT_FC_INIT     = 4'd1,
        BOOT_LC_INIT     = 4'd2,
        BOOT_BRKPOINT    = 4'd3,
        BOOT_MCU_RUN     = 4'd4,
        BOOT_MCU_RST_REQ = 4'd5,
        BOOT_DONE        = 4'd6
    } boot_state_e;

    ////////////////////////////////////////
    // Register word addresses
    ////////////////////////////////////////
    localparam csr_addr_t CSR_BOOT_GO       = 6'd0;
    localparam csr_addr_t CSR_CPTRA_GO      = 6'd1;
    localparam csr_addr_t CSR_RESET_REQUEST = 6'd2;
    localparam csr_addr_t CSR_BOOT_STATUS   = 6'd3;
    localparam csr_addr_t CSR_WDT_CTRL      = 6'd4;
    localparam csr_addr_t CSR_WDT_T1_PERIOD = 6'd5;
    localparam csr_addr_t CSR_WDT_T2_PERIOD = 6'd6;
    localparam csr_addr_t CSR_WDT_STATUS    = 6'd7;
    localparam csr_addr_t CSR_GENERIC_OUT   = 6'd8;

    // Field positions
    localparam int GO_BIT           = 0;
    localparam int RST_REQ_BIT      = 0;
    localparam int RST_ONCE_BIT     = 4;
    localparam int WDT_EN_BIT       = 0;
    localparam int WDT_RESTART_BIT  = 1;
    localparam int WDT_T1_TO_BIT    = 0;
    localparam int WDT_T2_TO_BIT    = 1;

endpackage
